//--- hw/fifo_pkg.sv
package fifo_pkg;

   // Defaults for the mesh packet FIFO
   localparam int DW_DEFAULT    = 104;   // Packet width
   localparam int DEPTH_DEFAULT = 32;    // Entries, power of two

   // Widest pointer the conversions handle
   localparam int PTR_W_MAX = 16;

   //####################
   // Gray code helpers
   //####################
   // Callers zero-extend narrower pointers, which leaves the low bits exact
   function automatic logic [PTR_W_MAX-1:0] bin2gray(input logic [PTR_W_MAX-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic logic [PTR_W_MAX-1:0] gray2bin(input logic [PTR_W_MAX-1:0] gray);
      logic [PTR_W_MAX-1:0] bin;
      bin[PTR_W_MAX-1] = gray[PTR_W_MAX-1];
      for (int i = PTR_W_MAX - 2; i >= 0; i--)
      begin
         bin[i] = bin[i+1] ^ gray[i];   // Running XOR from the top
      end
      return bin;
   endfunction

endpackage

//--- hw/fifo_mem.sv
module fifo_mem
   import fifo_pkg::*;
#(
   parameter int DW    = DW_DEFAULT,
   parameter int DEPTH = DEPTH_DEFAULT
)
(
   input  logic                     wr_clk,
   input  logic                     wr_we,
   input  logic [$clog2(DEPTH)-1:0] wr_addr,
   input  logic [DW-1:0]            wr_data,
   input  logic                     rd_clk,
   input  logic                     rst,
   input  logic                     rd_re,
   input  logic [$clog2(DEPTH)-1:0] rd_addr,
   output logic [DW-1:0]            rd_data
);

   logic [DW-1:0] mem [DEPTH];   // Storage array

   // Write port
   always_ff @(posedge wr_clk)
   begin
      if (wr_we)
         mem[wr_addr] <= wr_data;
   end

   // Registered read port, held between reads
   always_ff @(posedge rd_clk or posedge rst)
   begin
      if (rst)
         rd_data <= '0;
      else if (rd_re)
         rd_data <= mem[rd_addr];
   end

endmodule

//--- hw/fifo_sync.sv
module fifo_sync
   import fifo_pkg::*;
#(
   parameter int W = $clog2(DEPTH_DEFAULT) + 1   // Pointer width
)
(
   input  logic         clk,   // Destination clock
   input  logic         rst,
   input  logic [W-1:0] d,
   output logic [W-1:0] q
);

   logic [W-1:0] meta;   // First stage, may go metastable

   // Gray input changes one bit per step, so
   // whatever gets sampled is an old or new pointer
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         meta <= '0;
         q    <= '0;
      end
      else
      begin
         meta <= d;
         q    <= meta;
      end
   end

endmodule

//--- hw/fifo_wr_ptr.sv
module fifo_wr_ptr
   import fifo_pkg::*;
#(
   parameter int DEPTH = DEPTH_DEFAULT
)
(
   input  logic                   wr_clk,
   input  logic                   rst,
   input  logic                   inc,        // Accepted write
   output logic [$clog2(DEPTH):0] bin,
   output logic [$clog2(DEPTH):0] bin_next,
   output logic [$clog2(DEPTH):0] gray
);

   localparam int AW = $clog2(DEPTH);
   localparam int PW = AW + 1;   // Extra wrap bit

   logic [PTR_W_MAX-1:0] gray_next;

   // Next value feeds the flag logic directly
   assign bin_next  = bin + {{AW{1'b0}}, inc};
   assign gray_next = bin2gray(PTR_W_MAX'(bin_next));

   //####################
   // Pointer registers
   //####################
   always_ff @(posedge wr_clk or posedge rst)
   begin
      if (rst)
      begin
         bin  <= '0;
         gray <= '0;
      end
      else
      begin
         bin  <= bin_next;
         gray <= gray_next[PW-1:0];   // Registered, safe to cross
      end
   end

endmodule

//--- hw/fifo_rd_ptr.sv
module fifo_rd_ptr
   import fifo_pkg::*;
#(
   parameter int DEPTH = DEPTH_DEFAULT
)
(
   input  logic                   rd_clk,
   input  logic                   rst,
   input  logic                   inc,        // Accepted read
   output logic [$clog2(DEPTH):0] bin,
   output logic [$clog2(DEPTH):0] bin_next,
   output logic [$clog2(DEPTH):0] gray
);

   localparam int AW = $clog2(DEPTH);
   localparam int PW = AW + 1;

   logic [PTR_W_MAX-1:0] gray_next;

   assign bin_next  = bin + {{AW{1'b0}}, inc};
   assign gray_next = bin2gray(PTR_W_MAX'(bin_next));

   //####################
   // Pointer registers
   //####################
   // Gray copy comes straight from a flop, no glitches into
   // the write domain
   always_ff @(posedge rd_clk or posedge rst)
   begin
      if (rst)
      begin
         bin  <= '0;
         gray <= '0;
      end
      else
      begin
         bin  <= bin_next;
         gray <= gray_next[PW-1:0];
      end
   end

endmodule

//--- hw/fifo_async_model.sv
module fifo_async_model
   import fifo_pkg::*;
#(
   parameter int DW         = DW_DEFAULT,
   parameter int DEPTH      = DEPTH_DEFAULT,
   parameter int PROG_LEVEL = DEPTH - 4     // Fill level for prog_full
)
(
   input  logic          rst,
   input  logic          wr_clk,
   input  logic          rd_clk,
   input  logic          wr_en,
   input  logic [DW-1:0] din,
   input  logic          rd_en,
   output logic          full,
   output logic          prog_full,
   output logic [DW-1:0] dout,
   output logic          empty,
   output logic          valid
);

   localparam int AW = $clog2(DEPTH);
   localparam int PW = AW + 1;

   logic                 wr_inc;
   logic                 rd_inc;
   logic [PW-1:0]        wr_bin, wr_bin_next, wr_gray;
   logic [PW-1:0]        rd_bin, rd_bin_next, rd_gray;
   logic [PW-1:0]        wr_rgray;       // Read pointer seen from wr_clk
   logic [PW-1:0]        rd_wgray;       // Write pointer seen from rd_clk
   logic [PTR_W_MAX-1:0] wr_rbin_wide;
   logic [PTR_W_MAX-1:0] rd_wbin_wide;
   logic [PW-1:0]        wr_rbin;
   logic [PW-1:0]        rd_wbin;
   logic [PW-1:0]        wr_count_next;  // Fill level after this edge

   // Strobes are dropped at the boundaries
   assign wr_inc = wr_en & ~full;
   assign rd_inc = rd_en & ~empty;

   //####################
   // Pointers and sync
   //####################
   fifo_wr_ptr #(.DEPTH(DEPTH)) u_wr_ptr
   (
      .wr_clk   (wr_clk),
      .rst      (rst),
      .inc      (wr_inc),
      .bin      (wr_bin),
      .bin_next (wr_bin_next),
      .gray     (wr_gray)
   );

   fifo_rd_ptr #(.DEPTH(DEPTH)) u_rd_ptr
   (
      .rd_clk   (rd_clk),
      .rst      (rst),
      .inc      (rd_inc),
      .bin      (rd_bin),
      .bin_next (rd_bin_next),
      .gray     (rd_gray)
   );

   fifo_sync #(.W(PW)) u_sync_w2r (.clk(rd_clk), .rst(rst), .d(wr_gray), .q(rd_wgray));
   fifo_sync #(.W(PW)) u_sync_r2w (.clk(wr_clk), .rst(rst), .d(rd_gray), .q(wr_rgray));

   assign wr_rbin_wide  = gray2bin(PTR_W_MAX'(wr_rgray));
   assign rd_wbin_wide  = gray2bin(PTR_W_MAX'(rd_wgray));
   assign wr_rbin       = wr_rbin_wide[PW-1:0];
   assign rd_wbin       = rd_wbin_wide[PW-1:0];
   assign wr_count_next = wr_bin_next - wr_rbin;   // Wraps cleanly mod 2*DEPTH

   fifo_mem #(.DW(DW), .DEPTH(DEPTH)) u_mem
   (
      .wr_clk  (wr_clk),
      .wr_we   (wr_inc),
      .wr_addr (wr_bin[AW-1:0]),
      .wr_data (din),
      .rd_clk  (rd_clk),
      .rst     (rst),
      .rd_re   (rd_inc),
      .rd_addr (rd_bin[AW-1:0]),
      .rd_data (dout)
   );

   //####################
   // Write side flags
   //####################
   // Full when a whole lap ahead of the reader
   always_ff @(posedge wr_clk or posedge rst)
   begin
      if (rst)
      begin
         full      <= 1'b0;
         prog_full <= 1'b0;
      end
      else
      begin
         full      <= (wr_bin_next == {~wr_rbin[AW], wr_rbin[AW-1:0]});
         prog_full <= (wr_count_next >= PW'(PROG_LEVEL));
      end
   end

   //####################
   // Read side flags
   //####################
   always_ff @(posedge rd_clk or posedge rst)
   begin
      if (rst)
      begin
         empty <= 1'b1;   // Nothing written yet
         valid <= 1'b0;
      end
      else
      begin
         empty <= (rd_bin_next == rd_wbin);
         valid <= rd_inc;   // Lines up with dout load
      end
   end

endmodule

//--- hw/fifo_async.sv
module fifo_async
   import fifo_pkg::*;
#(
   parameter int DW    = DW_DEFAULT,
   parameter int DEPTH = DEPTH_DEFAULT,
   parameter int WAIT  = 1               // Random prog_full stalls
)
(
   input  logic          rst,        // Both domains
   input  logic          wr_clk,
   input  logic          rd_clk,
   input  logic          wr_en,
   input  logic [DW-1:0] din,
   output logic          full,
   output logic          prog_full,
   input  logic          rd_en,
   output logic [DW-1:0] dout,
   output logic          empty,
   output logic          valid
);

   logic fifo_prog_full;
   logic wait_random;

   fifo_async_model #(.DW(DW), .DEPTH(DEPTH)) u_fifo
   (
      .rst       (rst),
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .wr_en     (wr_en),
      .din       (din),
      .rd_en     (rd_en),
      .full      (full),
      .prog_full (fifo_prog_full),
      .dout      (dout),
      .empty     (empty),
      .valid     (valid)
   );

   // Stall writer by faking prog_full
   assign prog_full = fifo_prog_full | wait_random;

   //####################
   // Wait generator
   //####################
   if (WAIT != 0)
   begin : g_wait
      logic [7:0] wait_counter;

      always_ff @(posedge wr_clk or posedge rst)
      begin
         if (rst)
            wait_counter <= '0;
         else
            wait_counter <= wait_counter + 8'd1;
      end

      // Low one cycle in 32
      assign wait_random = |wait_counter[4:0];
   end
   else
   begin : g_no_wait
      assign wait_random = 1'b0;
   end

endmodule

//--- tb/fifo_async_tb.sv
module fifo_async_tb
   import fifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DW         = DW_DEFAULT;
   localparam int DEPTH      = DEPTH_DEFAULT;
   localparam int PROG_LEVEL = DEPTH - 4;   // Core default threshold
   localparam int N_STREAM   = 300;

   logic          rst;
   logic          wr_clk;
   logic          rd_clk;
   logic          wr_en;
   logic [DW-1:0] din;
   logic          rd_en;
   logic          full;
   logic          prog_full;
   logic [DW-1:0] dout;
   logic          empty;
   logic          valid;

   integer        seed = 32'h73b1_7270;
   logic [DW-1:0] exp_q [$];        // Packets in write order with the oldest in front
   int            errors      = 0;
   int            checks      = 0;
   int            valid_count = 0;  // Read results seen so far

   fifo_async #(.DW(DW), .DEPTH(DEPTH), .WAIT(1)) dut
   (
      .rst       (rst),
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .wr_en     (wr_en),
      .din       (din),
      .full      (full),
      .prog_full (prog_full),
      .rd_en     (rd_en),
      .dout      (dout),
      .empty     (empty),
      .valid     (valid)
   );

   initial
   begin
      wr_clk = 1'b0;
      forever #50 wr_clk = ~wr_clk;
   end

   initial
   begin
      rd_clk = 1'b0;
      forever #35 rd_clk = ~rd_clk;
   end

   //####################
   // Reference model
   //####################
   function automatic logic [DW-1:0] random_packet();
      logic [127:0] wide;
      wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
      return wide[DW-1:0];
   endfunction

   // Next packet in write order
   function automatic logic [DW-1:0] expected_packet();
      return exp_q.pop_front();
   endfunction

   //####################
   // Checks
   //####################
   task automatic check_data(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                             input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
      end
   endtask

   task automatic check_count(input int actual, input int expected, input string what);
      checks++;
      if (actual != expected)
      begin
         errors++;
         $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   // Compare every read result against the model
   always @(negedge rd_clk)
   begin
      if (!rst && valid)
      begin
         valid_count++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Read result appeared with no packet outstanding at %0d ns", $time);
         end
         else
            check_data(dout, expected_packet(), "dout");
      end
   end

   //####################
   // Drivers
   //####################
   task automatic wr_tick();
      @(posedge wr_clk);
      #5;
   endtask

   task automatic rd_tick();
      @(posedge rd_clk);
      #5;
   endtask

   task automatic timeout(input string what);
      errors++;
      $display("Timed out while %s at %0d ns", what, $time);
   endtask

   // Writer stops on full alone since prog_full is advisory
   task automatic write_packets(input int count, input bit gaps);
      int sent;
      int cycles;
      sent   = 0;
      cycles = 0;
      while (sent < count && cycles < count * 8 + 20)
      begin
         wr_tick();
         cycles++;
         if (!full && (!gaps || ($random(seed) & 3) != 0))
         begin
            din   = random_packet();
            wr_en = 1'b1;
            exp_q.push_back(din);
            sent++;
         end
         else
            wr_en = 1'b0;
      end
      wr_tick();
      wr_en = 1'b0;
      if (sent < count)
         timeout("writing packets");
   endtask

   task automatic read_packets(input int count, input bit gaps);
      int target;
      int cycles;
      target = valid_count + count;
      cycles = 0;
      while (valid_count < target && cycles < count * 12 + 20)
      begin
         rd_tick();
         cycles++;
         rd_en = !gaps || (($random(seed) & 1) == 1);
      end
      rd_en = 1'b0;
      if (valid_count < target)
         timeout("reading packets");
   endtask

   task automatic wait_not_empty(input int limit);
      int cycles;
      cycles = 0;
      while (empty && cycles < limit)
      begin
         rd_tick();
         cycles++;
      end
      if (empty)
         timeout("waiting for empty to fall");
   endtask

   task automatic wait_valid_count(input int target, input int limit);
      int cycles;
      cycles = 0;
      while (valid_count < target && cycles < limit)
      begin
         rd_tick();
         cycles++;
      end
      if (valid_count < target)
         timeout("waiting for valid");
   endtask

   //####################
   // Test sequence
   //####################
   initial
   begin
      int start;
      int accepted;
      int cycles;

      rst   = 1'b1;
      wr_en = 1'b0;
      din   = '0;
      rd_en = 1'b0;
      repeat (5) @(posedge wr_clk);
      #5;
      rst = 1'b0;

      // Reset state, then one wait-counter lap
      check_flag(empty, 1'b1, "empty after reset");
      check_flag(full, 1'b0, "full after reset");
      check_flag(valid, 1'b0, "valid after reset");
      check_data(dout, '0, "dout after reset");
      for (int k = 0; k <= 32; k++)
      begin
         check_flag(prog_full, (k % 32) != 0, "prog_full wait pattern");
         wr_tick();
      end

      // Single packet
      write_packets(1, 1'b0);
      wait_not_empty(10);
      start = valid_count;
      rd_tick();
      rd_en = 1'b1;
      rd_tick();
      rd_en = 1'b0;
      wait_valid_count(start + 1, 10);
      repeat (3)
      begin
         check_flag(valid, 1'b0, "valid after single read");
         rd_tick();
      end
      check_count(valid_count - start, 1, "valid pulses for one read");

      // Ordered streaming with random gaps on both sides
      fork
         write_packets(N_STREAM, 1'b1);
         read_packets(N_STREAM, 1'b1);
      join
      check_count(exp_q.size(), 0, "packets left after streaming");

      // Fill to full with the reader idle
      repeat (6) wr_tick();   // Read pointer settles in write domain
      accepted = 0;
      cycles   = 0;
      while (!full && cycles < DEPTH * 2 + 8)
      begin
         din   = random_packet();
         wr_en = 1'b1;
         exp_q.push_back(din);
         accepted++;
         wr_tick();
         cycles++;
      end
      wr_en = 1'b0;
      if (!full)
         timeout("waiting for full");
      check_count(accepted, DEPTH, "writes accepted before full");
      repeat (3)
      begin
         din   = random_packet();   // Must be dropped
         wr_en = 1'b1;
         check_flag(full, 1'b1, "full during extra writes");
         wr_tick();
      end
      wr_en = 1'b0;

      // Drain, then poke at an empty FIFO
      read_packets(DEPTH, 1'b0);
      rd_tick();
      check_flag(empty, 1'b1, "empty after drain");
      check_count(exp_q.size(), 0, "packets left after drain");
      start = valid_count;
      repeat (5)
      begin
         rd_en = 1'b1;
         rd_tick();
      end
      rd_en = 1'b0;
      repeat (2) rd_tick();
      check_count(valid_count, start, "valid pulses while empty");

      // Threshold holds prog_full through a whole wait lap
      repeat (6) wr_tick();
      write_packets(PROG_LEVEL, 1'b0);
      repeat (40)
      begin
         check_flag(prog_full, 1'b1, "prog_full at threshold");
         wr_tick();
      end
      read_packets(PROG_LEVEL, 1'b0);
      check_count(exp_q.size(), 0, "packets left at end");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- emesh_fifo.f
hw/fifo_pkg.sv
hw/fifo_mem.sv
hw/fifo_sync.sv
hw/fifo_wr_ptr.sv
hw/fifo_rd_ptr.sv
hw/fifo_async_model.sv
hw/fifo_async.sv
tb/fifo_async_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   -f emesh_fifo.f \
   --top-module fifo_async_tb \
   -Mdir obj_dir \
   -o fifo_async_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/fifo_async_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" <<< "$output"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
